// File: compile.f
verilog/intcPkg.sv
verilog/intcCfgIf.sv
verilog/intcRegs.sv
verilog/intcPinDetect.sv
verilog/intcArbiter.sv
verilog/intcTop.sv
sim/intcTb.sv

// File: sim/intcTests.txt
# op and hex args: W addr data | R addr expected | M mask | C cycles | N no interrupt
# P nmiN irqN dmacIrq wdtIrq sciIrq | I level vector, then acknowledge
R 3 0000
W 0 9876
W 1 1234
W 2 5a73
R 0 9876
R 1 1234
R 2 5a73
W 3 ffff
R 3 0100
W 3 feff
R 3 0000
M 7
P 1 ff 0 1 0
N
M 6
I 7 70
P 1 ff 0 0 0
N
M f
P 1 fe 1 0 0
C 4
M 0
C 2
P 1 ff 1 0 0
C 2
I 9 40
I 5 48
P 1 ff 2 0 0
I 5 4a
P 1 ff 0 0 a
I 3 65
P 1 ff 0 0 8
I 3 67
P 1 ff 0 0 0
N
M 5
P 1 f7 0 0 0
C 5
P 1 ff 0 0 0
I 6 43
N
M f
P 0 ff 0 0 0
I f 0b
P 1 ff 0 0 0
N
W 3 0100
P 0 ff 0 0 0
N
P 1 ff 0 0 0
I f 0b
N

// File: sim/intcTb.sv
`timescale 1ns/1ps

module intcTb;

	import intcPkg::*;

	// cycles to wait for an interrupt, or to watch for its absence
	localparam int waitLimit = 20;

	logic       CLK;
	logic       RST_N;
	logic       regReq;
	logic       regWe;
	regAddr_e   regAddr;
	regData_t   regWdata;
	regData_t   regRdata;
	logic       nmiN;
	logic [7:0] irqN;
	logic [3:0] dmacIrq;
	logic       wdtIrq;
	logic [3:0] sciIrq;
	prioLevel_t intMask;
	logic       intAck;
	logic       intReq;
	prioLevel_t intLvl;
	vector_t    intVec;

	int    valueErrors = 0;
	int    eventErrors = 0;
	int    cycleCount = 0;
	int    cycleLimit = 0;
	string lines[$];

	intcTop dut (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// the limit is set once the test lines are known
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("run stopped after %0d cycles before the tests were done", cycleCount);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic checkReg(input string name, input regData_t got, input regData_t exp);
		if (got !== exp) begin
			valueErrors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkLvl(input string name, input prioLevel_t got, input prioLevel_t exp);
		if (got !== exp) begin
			valueErrors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkVec(input string name, input vector_t got, input vector_t exp);
		if (got !== exp) begin
			valueErrors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			valueErrors++;
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// every command starts and ends just after a falling edge
	task automatic writeReg(input logic [1:0] addr, input regData_t data);
		regReq = 1'b1;
		regWe = 1'b1;
		regAddr = regAddr_e'(addr);
		regWdata = data;
		@(negedge CLK);
		regReq = 1'b0;
		regWe = 1'b0;
	endtask

	task automatic readReg(input logic [1:0] addr, input regData_t exp);
		regReq = 1'b1;
		regWe = 1'b0;
		regAddr = regAddr_e'(addr);
		@(negedge CLK);
		regReq = 1'b0;
		checkReg("regRdata", regRdata, exp);
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(negedge CLK);
	endtask

	task automatic acknowledge();
		intAck = 1'b1;
		@(negedge CLK);
		intAck = 1'b0;
	endtask

	task automatic expectInt(input prioLevel_t lvl, input vector_t vec);
		int n;
		n = 0;
		while (!intReq && n < waitLimit) begin
			@(negedge CLK);
			n++;
		end
		if (!intReq) begin
			eventErrors++;
			$display("no interrupt within %0d cycles at %0t, expected vector %h",
				waitLimit, $time, vec);
		end else begin
			checkLvl("intLvl", intLvl, lvl);
			checkVec("intVec", intVec, vec);
			acknowledge();
			checkBit("intReq", intReq, 1'b0);
		end
	endtask

	task automatic expectNone();
		int n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < waitLimit && !seen; n++) begin
			@(negedge CLK);
			if (intReq) begin
				seen = 1'b1;
				eventErrors++;
				$display("unexpected interrupt at %0t with vector %h", $time, intVec);
				acknowledge();
			end
		end
	endtask

	initial begin
		int          fd;
		int          count;
		byte         op;
		logic [15:0] a0;
		logic [15:0] a1;
		logic [15:0] a2;
		logic [15:0] a3;
		logic [15:0] a4;
		string       line;
		RST_N = 1'b0;
		regReq = 1'b0;
		regWe = 1'b0;
		regAddr = addrIpra;
		regWdata = '0;
		nmiN = 1'b1;
		irqN = '1;
		dmacIrq = '0;
		wdtIrq = 1'b0;
		sciIrq = '0;
		intMask = '0;
		intAck = 1'b0;

		fd = $fopen("sim/intcTests.txt", "r");
		if (fd == 0) begin
			eventErrors++;
			$display("cannot open the test file sim/intcTests.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				count = $fgets(line, fd);
				if (count > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		cycleLimit = 40 * lines.size() + 20;

		repeat (8) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		checkBit("intReq", intReq, 1'b0);
		checkLvl("intLvl", intLvl, 4'hf);
		checkVec("intVec", intVec, 8'h00);
		checkReg("regRdata", regRdata, 16'h0000);

		foreach (lines[i]) begin
			a0 = '0;
			a1 = '0;
			a2 = '0;
			a3 = '0;
			a4 = '0;
			count = $sscanf(lines[i], "%c %h %h %h %h %h", op, a0, a1, a2, a3, a4);
			case (op)
				"W": writeReg(a0[1:0], a1);
				"R": readReg(a0[1:0], a1);
				"M": intMask = a0[3:0];
				"C": waitCycles(a0);
				"P": begin
					nmiN = a0[0];
					irqN = a1[7:0];
					dmacIrq = a2[3:0];
					wdtIrq = a3[0];
					sciIrq = a4[3:0];
				end
				"I": expectInt(a0[3:0], a1[7:0]);
				"N": expectNone();
				default: begin
					eventErrors++;
					$display("unknown command in test line: %s", lines[i]);
				end
			endcase
		end

		$display("errors: %0d value mismatches, %0d missing or unexpected events",
			valueErrors, eventErrors);
		if (valueErrors == 0 && eventErrors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/intcTop.sv
`timescale 1ns/1ps

module intcTop #(
	parameter int unsigned irqSampleDepth = 2
) (
	input  logic                 CLK,
	input  logic                 RST_N,

	input  logic                 regReq,
	input  logic                 regWe,
	input  intcPkg::regAddr_e    regAddr,
	input  intcPkg::regData_t    regWdata,
	output intcPkg::regData_t    regRdata,

	input  logic                 nmiN,
	input  logic [7:0]           irqN,

	input  logic [3:0]           dmacIrq,
	input  logic                 wdtIrq,
	input  logic [3:0]           sciIrq,

	input  intcPkg::prioLevel_t  intMask,
	input  logic                 intAck,
	output logic                 intReq,
	output intcPkg::prioLevel_t  intLvl,
	output intcPkg::vector_t     intVec
);

	logic       nmiReq;
	logic [7:0] irqReq;
	logic       nmiTaken;

	intcCfgIf cfg ();

	intcRegs uRegs (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.cfg      (cfg.regs),
		.regReq   (regReq),
		.regWe    (regWe),
		.regAddr  (regAddr),
		.regWdata (regWdata),
		.regRdata (regRdata)
	);

	intcPinDetect #(
		.irqSampleDepth (irqSampleDepth)
	) uPinDetect (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.cfg      (cfg.pins),
		.nmiN     (nmiN),
		.irqN     (irqN),
		.nmiTaken (nmiTaken),
		.nmiReq   (nmiReq),
		.irqReq   (irqReq)
	);

	intcArbiter uArbiter (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.cfg      (cfg.arb),
		.nmiReq   (nmiReq),
		.irqReq   (irqReq),
		.dmacIrq  (dmacIrq),
		.wdtIrq   (wdtIrq),
		.sciIrq   (sciIrq),
		.intMask  (intMask),
		.intAck   (intAck),
		.intReq   (intReq),
		.intLvl   (intLvl),
		.intVec   (intVec),
		.nmiTaken (nmiTaken)
	);

endmodule

// File: verilog/intcArbiter.sv
`timescale 1ns/1ps

module intcArbiter (
	input  logic                 CLK,
	input  logic                 RST_N,
	intcCfgIf.arb                cfg,
	input  logic                 nmiReq,
	input  logic [7:0]           irqReq,
	input  logic [3:0]           dmacIrq,
	input  logic                 wdtIrq,
	input  logic [3:0]           sciIrq,
	input  intcPkg::prioLevel_t  intMask,
	input  logic                 intAck,
	output logic                 intReq,
	output intcPkg::prioLevel_t  intLvl,
	output intcPkg::vector_t     intVec,
	output logic                 nmiTaken
);

	import intcPkg::*;

	arbState_e  state;
	intSource_e pendSrc;
	intSource_e scanSrc;
	logic [2:0] irqIdx;
	logic [1:0] dmacIdx;
	logic [1:0] sciIdx;

	// the scan runs from the end of the order backwards, so the earliest source
	// that qualifies is the one left in scanSrc
	always_comb begin
		scanSrc = srcNone;
		for (int i = 3; i >= 0; i--) begin
			if (sciIrq[i] && cfg.sciPrio > intMask) begin
				scanSrc = intSource_e'(srcSciEri + i);
			end
		end
		if (wdtIrq && cfg.wdtPrio > intMask) begin
			scanSrc = srcWdt;
		end
		for (int i = 3; i >= 0; i--) begin
			if (dmacIrq[i] && cfg.dmacPrio[i >> 1] > intMask) begin
				scanSrc = intSource_e'(srcDmac0 + i);
			end
		end
		for (int i = 7; i >= 0; i--) begin
			if (irqReq[i] && cfg.irqPrio[i] > intMask) begin
				scanSrc = intSource_e'(srcIrq0 + i);
			end
		end
		// NMI ignores the mask
		if (nmiReq) begin
			scanSrc = srcNmi;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state   <= arbIdle;
			pendSrc <= srcNone;
		end else begin
			case (state)
				arbIdle: begin
					pendSrc <= scanSrc;
					if (scanSrc != srcNone) begin
						state <= arbPending;
					end
				end
				arbPending: begin
					if (intAck) begin
						pendSrc <= srcNone;
						state   <= arbIdle;
					end
				end
				default: state <= arbIdle;
			endcase
		end
	end

	assign intReq   = (state == arbPending);
	// clears the NMI request on the same edge the arbiter returns to idle
	assign nmiTaken = intReq && intAck && (pendSrc == srcNmi);

	assign irqIdx  = 3'(pendSrc - srcIrq0);
	assign dmacIdx = 2'(pendSrc - srcDmac0);
	assign sciIdx  = 2'(pendSrc - srcSciEri);

	// levels follow the live priority registers, vectors come from the table
	always_comb begin
		case (pendSrc) inside
			srcNmi: begin
				intLvl = nmiLevel;
				intVec = nmiVector;
			end
			[srcIrq0:srcIrq7]: begin
				intLvl = cfg.irqPrio[irqIdx];
				intVec = vector_t'(irqVectorBase + irqIdx);
			end
			[srcDmac0:srcDmac3]: begin
				intLvl = cfg.dmacPrio[dmacIdx[1]];
				intVec = vector_t'(dmacVectorBase + {dmacIdx, 1'b0});
			end
			srcWdt: begin
				intLvl = cfg.wdtPrio;
				intVec = wdtVector;
			end
			[srcSciEri:srcSciTei]: begin
				intLvl = cfg.sciPrio;
				intVec = vector_t'(sciVectorBase + sciIdx);
			end
			default: begin
				intLvl = '1;
				intVec = '0;
			end
		endcase
	end

	// the CPU only acknowledges a request it has been shown
	assert property (@(posedge CLK) disable iff (!RST_N)
		intAck |-> intReq);

	// a pending request always carries a real vector
	assert property (@(posedge CLK) disable iff (!RST_N)
		intReq |-> intVec != '0);

endmodule

// File: verilog/intcPinDetect.sv
`timescale 1ns/1ps

module intcPinDetect #(
	parameter int unsigned irqSampleDepth = 2
) (
	input  logic        CLK,
	input  logic        RST_N,
	intcCfgIf.pins      cfg,
	input  logic        nmiN,
	input  logic [7:0]  irqN,
	input  logic        nmiTaken,
	output logic        nmiReq,
	output logic [7:0]  irqReq
);

	logic       nmiNReg;
	logic       nmiNOld;
	logic       nmiEdge;
	// a set bit means the pin was sampled low
	logic [7:0] irqLow [irqSampleDepth];

	// the pin is registered once, then the previous sample is kept for edge detection
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			nmiNReg <= 1'b1;
			nmiNOld <= 1'b1;
		end else begin
			nmiNReg <= nmiN;
			nmiNOld <= nmiNReg;
		end
	end

	assign nmiEdge = cfg.nmiRising ? (nmiNReg & ~nmiNOld) : (~nmiNReg & nmiNOld);

	// sticky request, a fresh edge wins over the acknowledge of the previous one
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			nmiReq <= 1'b0;
		end else if (nmiEdge) begin
			nmiReq <= 1'b1;
		end else if (nmiTaken) begin
			nmiReq <= 1'b0;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int k = 0; k < irqSampleDepth; k++) begin
				irqLow[k] <= '0;
			end
		end else begin
			irqLow[0] <= ~irqN;
			for (int k = 1; k < irqSampleDepth; k++) begin
				irqLow[k] <= irqLow[k - 1];
			end
		end
	end

	// level sensitive, requests only while the whole history is low
	always_comb begin
		irqReq = '1;
		for (int k = 0; k < irqSampleDepth; k++) begin
			irqReq = irqReq & irqLow[k];
		end
	end

	// the arbiter may only retire an NMI that this block is still requesting
	assert property (@(posedge CLK) disable iff (!RST_N)
		nmiTaken |-> nmiReq);

endmodule

// File: verilog/intcRegs.sv
`timescale 1ns/1ps

module intcRegs (
	input  logic               CLK,
	input  logic               RST_N,
	intcCfgIf.regs             cfg,
	input  logic               regReq,
	input  logic               regWe,
	input  intcPkg::regAddr_e  regAddr,
	input  intcPkg::regData_t  regWdata,
	output intcPkg::regData_t  regRdata
);

	import intcPkg::*;

	regData_t ipra;
	regData_t iprb;
	regData_t iprc;
	regData_t icr;

	logic wrStrobe;
	logic rdStrobe;

	assign wrStrobe = regReq & regWe;
	assign rdStrobe = regReq & ~regWe;

	// whole-word writes only, the control register keeps just the edge select
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ipra <= regResetVal;
			iprb <= regResetVal;
			iprc <= regResetVal;
			icr  <= regResetVal;
		end else if (wrStrobe) begin
			case (regAddr)
				addrIpra: ipra <= regWdata;
				addrIprb: iprb <= regWdata;
				addrIprc: iprc <= regWdata;
				addrIcr:  icr  <= regWdata & icrWriteMask;
				default: ;
			endcase
		end
	end

	// read data is captured on the strobe edge and held until the next read
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			regRdata <= '0;
		end else if (rdStrobe) begin
			case (regAddr)
				addrIpra: regRdata <= ipra;
				addrIprb: regRdata <= iprb;
				addrIprc: regRdata <= iprc;
				addrIcr:  regRdata <= icr;
				default:  regRdata <= '0;
			endcase
		end
	end

	// IRQ0 and IRQ4 live in the high nibble, element 7 is listed first
	assign cfg.irqPrio = {iprb[3:0], iprb[7:4], iprb[11:8], iprb[15:12],
		ipra[3:0], ipra[7:4], ipra[11:8], ipra[15:12]};

	// IPRC holds DMAC01, DMAC23, WDT and SCI from the top nibble down
	assign cfg.dmacPrio  = {iprc[11:8], iprc[15:12]};
	assign cfg.wdtPrio   = iprc[7:4];
	assign cfg.sciPrio   = iprc[3:0];
	assign cfg.nmiRising = icr[icrNmieBit];

	// a strobe with an unknown offset would corrupt an arbitrary register
	assert property (@(posedge CLK) disable iff (!RST_N)
		regReq |-> !$isunknown(regAddr));

endmodule

// File: verilog/intcCfgIf.sv
`timescale 1ns/1ps

interface intcCfgIf;
	import intcPkg::*;

	// priority fields unpacked from IPRA, IPRB and IPRC
	prioLevel_t [7:0] irqPrio;
	prioLevel_t [1:0] dmacPrio;
	prioLevel_t       wdtPrio;
	prioLevel_t       sciPrio;
	// NMI edge select taken from the control register
	logic             nmiRising;

	modport regs (output irqPrio, output dmacPrio, output wdtPrio, output sciPrio,
		output nmiRising);
	modport arb (input irqPrio, input dmacPrio, input wdtPrio, input sciPrio);
	modport pins (input nmiRising);

endinterface

// File: verilog/intcPkg.sv
package intcPkg;

	// basic widths shared by the register port, the CPU side and the scan
	typedef logic [3:0]  prioLevel_t;
	typedef logic [7:0]  vector_t;
	typedef logic [15:0] regData_t;

	// word offsets of the register port
	typedef enum logic [1:0] {
		addrIpra,
		addrIprb,
		addrIprc,
		addrIcr
	} regAddr_e;

	// source order here is also the fixed arbitration order
	typedef enum logic [4:0] {
		srcNone,
		srcNmi,
		srcIrq0,
		srcIrq1,
		srcIrq2,
		srcIrq3,
		srcIrq4,
		srcIrq5,
		srcIrq6,
		srcIrq7,
		srcDmac0,
		srcDmac1,
		srcDmac2,
		srcDmac3,
		srcWdt,
		srcSciEri,
		srcSciRxi,
		srcSciTxi,
		srcSciTei
	} intSource_e;

	typedef enum logic {
		arbIdle,
		arbPending
	} arbState_e;

	// exception vector numbers
	localparam vector_t nmiVector      = 8'd11;
	localparam vector_t irqVectorBase  = 8'd64;
	localparam vector_t dmacVectorBase = 8'd72;
	localparam vector_t wdtVector      = 8'd112;
	localparam vector_t sciVectorBase  = 8'd100;

	// NMI sits above every maskable level
	localparam prioLevel_t nmiLevel = 4'd15;

	// edge select position in the control register, 1 selects the rising edge
	localparam int icrNmieBit = 8;
	localparam regData_t icrWriteMask = regData_t'(1 << icrNmieBit);

	localparam regData_t regResetVal = '0;

endpackage
